//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = sgb_tb
FILELIST = filelist.f
BUILD    = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

//--- bench/sgb_checker.sv
`timescale 1ns/1ps

module sgb_checker (
	input logic       clk_sys,
	input logic       reset,
	input logic       ce,
	input logic       byte_valid,
	input logic       pal_wr,
	input logic [3:0] joy_do,
	input logic       sgb_lcd_freeze,
	input logic       sgb_pal_en
);

	// Palette clear window, sixteen cycles after reset
	logic [4:0] clear_left;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clear_left <= 5'd16;
		end else if (ce && clear_left != 5'd0) begin
			clear_left <= clear_left - 5'd1;
		end
	end

	freeze_needs_pal_en: assert property (@(posedge clk_sys) disable iff (reset)
		sgb_lcd_freeze |-> sgb_pal_en)
		else $error("sgb_lcd_freeze high while sgb_pal_en is low");

	byte_valid_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		byte_valid |=> !byte_valid)
		else $error("byte_valid held for more than one cycle");

	joy_do_known: assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown(joy_do))
		else $error("joy_do has unknown bits");

	no_write_in_clear: assert property (@(posedge clk_sys) disable iff (reset)
		clear_left != 5'd0 |-> !pal_wr)
		else $error("palette write while the clear is still running");

endmodule

bind sgb_top sgb_checker chk0 (
	.clk_sys(clk_sys),
	.reset(reset),
	.ce(ce),
	.byte_valid(byte_valid),
	.pal_wr(pal_wr),
	.joy_do(joy_do),
	.sgb_lcd_freeze(sgb_lcd_freeze),
	.sgb_pal_en(sgb_pal_en)
);

//--- bench/sgb_tb.sv
`timescale 1ns/1ps
`include "sgb_config.svh"

module sgb_tb;
	import sgb_pkg::*;

	localparam int RESET_CYCLES = 16;
	// Reset pulse, two cycles per bit, stop bit and settling
	localparam int PACKET_CYCLES = 2 + `SGB_PACKET_BYTES * 8 * 2 + 2 + 4;
	localparam int PIXEL_CYCLES = 300;
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 7 * PACKET_CYCLES + PIXEL_CYCLES);

	logic clk_sys;
	logic reset;
	logic ce;
	logic sgb_en;
	logic tint;
	logic is_gbc_game;
	logic lcd_clkena;
	color_t lcd_data;
	gb_shade_t lcd_data_gb;
	logic [1:0] lcd_mode;
	logic lcd_on;
	logic lcd_vsync;
	logic [7:0] joystick_0;
	logic [7:0] joystick_1;
	logic [7:0] joystick_2;
	logic [7:0] joystick_3;
	logic [1:0] joy_p54;
	logic [3:0] joy_do;
	logic sgb_pal_en;
	color_t sgb_lcd_data;
	logic sgb_lcd_clkena;
	logic [1:0] sgb_lcd_mode;
	logic sgb_lcd_on;
	logic sgb_lcd_freeze;
	logic sgb_lcd_vsync;

	// Reference model state
	logic [31:0] rng_state;
	color_t exp_pal [0:15];
	logic exp_active;
	logic exp_div_en;
	logic [5:0] exp_div_pal;
	tile_coord_t exp_div_xy;
	logic [1:0] exp_mask_cmd;
	logic [1:0] exp_mask;
	logic exp_player;
	int pix_x;
	int cycle_cnt = 0;

	sgb_top dut0 (
		.clk_sys(clk_sys), .reset(reset), .ce(ce), .sgb_en(sgb_en),
		.tint(tint), .is_gbc_game(is_gbc_game), .lcd_clkena(lcd_clkena),
		.lcd_data(lcd_data), .lcd_data_gb(lcd_data_gb), .lcd_mode(lcd_mode),
		.lcd_on(lcd_on), .lcd_vsync(lcd_vsync),
		.joystick_0(joystick_0), .joystick_1(joystick_1),
		.joystick_2(joystick_2), .joystick_3(joystick_3),
		.joy_p54(joy_p54), .joy_do(joy_do), .sgb_pal_en(sgb_pal_en),
		.sgb_lcd_data(sgb_lcd_data), .sgb_lcd_clkena(sgb_lcd_clkena),
		.sgb_lcd_mode(sgb_lcd_mode), .sgb_lcd_on(sgb_lcd_on),
		.sgb_lcd_freeze(sgb_lcd_freeze), .sgb_lcd_vsync(sgb_lcd_vsync)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failures found");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic [127:0] put_byte(input logic [127:0] pkt, input int n,
		input sgb_byte_t b);
		return pkt | (128'(b) << (8 * n));
	endfunction

	// Joystick bit 0 right, 1 left, 2 down, 3 up, 7:4 start select B A
	function automatic logic [3:0] pad_nibble(input logic [7:0] j, input logic [1:0] lines);
		logic [3:0] n;
		n = 4'hf;
		if (!lines[0]) n = n & ~{j[2], j[3], j[1], j[0]};
		if (!lines[1]) n = n & ~j[7:4];
		return n;
	endfunction

	function automatic pal_no_t region_pal(input int x);
		int tile;
		tile = x / 8;
		if (!exp_div_en) return 2'd0;
		if (tile > int'(exp_div_xy)) return exp_div_pal[1:0];
		if (tile < int'(exp_div_xy)) return exp_div_pal[3:2];
		return exp_div_pal[5:4];
	endfunction

	task automatic check_equal(input logic [31:0] got, input logic [31:0] want,
		input string what);
		assert (got === want) else begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want);
			$display("Test failures found");
			$fatal(1, "stopping at the first error");
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	// joy_p54 is {p15, p14}
	task automatic drive_lines(input logic [1:0] lines);
		joy_p54 = lines;
		@(negedge clk_sys);
	endtask

	task automatic send_packet(input logic [127:0] bits);
		drive_lines(2'b00);
		drive_lines(2'b11);
		repeat (`SGB_PACKET_BYTES * 8) begin
			drive_lines(bits[0] ? 2'b01 : 2'b10);
			drive_lines(2'b11);
			bits = bits >> 1;
		end
		drive_lines(2'b10);
		drive_lines(2'b11);
		wait_cycles(4);
	endtask

	task automatic send_pal_cmd(input logic [4:0] cmd, input pal_no_t first,
		input pal_no_t second);
		logic [127:0] pkt;
		color_t c;
		pkt = 128'({cmd, 3'd1});
		for (int k = 0; k < 7; k++) begin
			c = color_t'(next_random());
			pkt = put_byte(pkt, 2 * k + 1, c[7:0]);
			pkt = put_byte(pkt, 2 * k + 2, {1'b0, c[14:8]});
			if (k == 0) exp_pal[0] = c;
			else if (k < 4) exp_pal[{first, 2'(k)}] = c;
			else exp_pal[{second, 2'(k - 3)}] = c;
		end
		send_packet(pkt);
		exp_active = 1'b1;
	endtask

	task automatic send_mask(input logic [1:0] mask);
		send_packet(put_byte(128'({`SGB_CMD_MASK_EN, 3'd1}), 1, {6'd0, mask}));
		exp_mask_cmd = mask;
		if (!lcd_on) exp_mask = mask;
	endtask

	// Switching off parks the pixel counter and loads the pending mask
	task automatic lcd_power(input logic on);
		lcd_on = on;
		wait_cycles(3);
		check_equal(32'(sgb_lcd_on), 32'(on), "sgb_lcd_on");
		pix_x = 0;
		if (!on) exp_mask = exp_mask_cmd;
	endtask

	task automatic skip_pixels(input int n);
		lcd_clkena = 1'b1;
		wait_cycles(n);
		lcd_clkena = 1'b0;
		pix_x = pix_x + n;
	endtask

	task automatic check_pixel(input gb_shade_t shade);
		color_t raw;
		color_t want;
		logic pass;
		logic vsync;
		raw = color_t'(next_random());
		vsync = 1'(next_random());
		lcd_data = raw;
		lcd_data_gb = shade;
		lcd_vsync = vsync;
		lcd_mode = 2'd3;
		lcd_clkena = 1'b1;
		wait_cycles(1);
		lcd_clkena = 1'b0;
		lcd_vsync = 1'b0;
		lcd_mode = 2'd0;
		wait_cycles(1);
		pass = !sgb_en || (exp_mask == 2'd0 && (!exp_active || tint || is_gbc_game));
		if (pass) want = raw;
		else if (exp_mask == 2'd2) want = '0;
		else if (shade == 2'd0 || exp_mask == 2'd3) want = exp_pal[0];
		else want = exp_pal[{region_pal(pix_x), shade}];
		check_equal(32'(sgb_lcd_data), 32'(want), "sgb_lcd_data");
		check_equal(32'(sgb_lcd_clkena), 32'd1, "sgb_lcd_clkena");
		check_equal(32'(sgb_lcd_mode), 32'd3, "sgb_lcd_mode");
		check_equal(32'(sgb_lcd_vsync), 32'(vsync), "sgb_lcd_vsync");
		check_equal(32'(sgb_lcd_freeze), 32'(sgb_en && exp_mask == 2'd1), "sgb_lcd_freeze");
		check_equal(32'(sgb_pal_en), 32'(sgb_en && ((exp_active && !tint && !is_gbc_game)
			|| exp_mask != 2'd0)), "sgb_pal_en");
		pix_x = pix_x + 1;
	endtask

	task automatic test_single_player();
		sgb_en = 1'b0;
		repeat (4) begin
			joystick_0 = 8'(next_random());
			joystick_1 = 8'(next_random());
			for (int l = 0; l < 4; l++) begin
				drive_lines(2'(l));
				check_equal(32'(joy_do), 32'(pad_nibble(joystick_0 | joystick_1, joy_p54)),
					"joy_do single player");
			end
		end
	endtask

	task automatic test_multiplayer();
		sgb_en = 1'b1;
		joystick_0 = 8'(next_random());
		joystick_1 = 8'(next_random());
		send_packet(put_byte(128'({`SGB_CMD_MLT_REQ, 3'd1}), 1, 8'h01));
		// The rest of the packet is zero bits, so p15 never rises once two players are on
		exp_player = 1'b0;
		repeat (5) begin
			check_equal(32'(joy_do), 32'({3'b111, ~exp_player}), "joy_do player index");
			drive_lines(2'b01);
			check_equal(32'(joy_do), 32'(pad_nibble(exp_player ? joystick_1 : joystick_0,
				2'b01)), "joy_do buttons");
			drive_lines(2'b11);
			wait_cycles(1);
			exp_player = ~exp_player;
		end
	endtask

	task automatic test_pal01();
		send_pal_cmd(`SGB_CMD_PAL01, 2'd0, 2'd1);
		lcd_power(1'b1);
		for (int s = 0; s < 4; s++) check_pixel(2'(s));
		tint = 1'b1;
		for (int s = 0; s < 4; s++) check_pixel(2'(s));
		tint = 1'b0;
		lcd_power(1'b0);
	endtask

	task automatic test_attr_div();
		logic [127:0] pkt;
		send_pal_cmd(`SGB_CMD_PAL23, 2'd2, 2'd3);
		exp_div_pal = 6'(next_random());
		exp_div_xy = tile_coord_t'(2 + next_random() % 16);
		pkt = put_byte(128'({`SGB_CMD_ATTR_DIV, 3'd1}), 1, {2'b00, exp_div_pal});
		pkt = put_byte(pkt, 2, {3'b000, exp_div_xy});
		send_packet(pkt);
		exp_div_en = 1'b1;
		lcd_power(1'b1);
		repeat (`SGB_TILES_X) begin
			check_pixel(gb_shade_t'(next_random()));
			skip_pixels(7);
		end
		lcd_power(1'b0);
	endtask

	task automatic test_mask();
		send_mask(2'd1);
		lcd_power(1'b1);
		check_pixel(2'd2);
		// Mask 1 stays in force until the LCD goes off
		send_mask(2'd2);
		check_pixel(2'd3);
		lcd_power(1'b0);
		lcd_power(1'b1);
		check_pixel(2'd1);
		send_mask(2'd3);
		lcd_power(1'b0);
		lcd_power(1'b1);
		check_pixel(2'd2);
		lcd_power(1'b0);
	endtask

	initial begin
		rng_state = 32'hd6e07a58;
		reset = 1'b1;
		ce = 1'b1;
		sgb_en = 1'b0;
		tint = 1'b0;
		is_gbc_game = 1'b0;
		lcd_clkena = 1'b0;
		lcd_data = '0;
		lcd_data_gb = '0;
		lcd_mode = 2'd0;
		lcd_on = 1'b0;
		lcd_vsync = 1'b0;
		joystick_0 = '0;
		joystick_1 = '0;
		joystick_2 = '0;
		joystick_3 = '0;
		joy_p54 = 2'b11;
		exp_pal = '{default: '0};
		exp_active = 1'b0;
		exp_div_en = 1'b0;
		exp_div_pal = '0;
		exp_div_xy = '0;
		exp_mask_cmd = 2'd0;
		exp_mask = 2'd0;
		exp_player = 1'b0;
		pix_x = 0;
		wait_cycles(RESET_CYCLES);
		reset = 1'b0;
		wait_cycles(1);
		test_single_player();
		test_multiplayer();
		test_pal01();
		test_attr_div();
		test_mask();
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+include
rtl/sgb_pkg.sv
rtl/sgb_packet_rx.sv
rtl/sgb_cmd_decode.sv
rtl/sgb_joypad_mux.sv
rtl/sgb_palette.sv
rtl/sgb_lcd_colorize.sv
rtl/sgb_top.sv
bench/sgb_checker.sv
bench/sgb_tb.sv

//--- include/sgb_config.svh
`ifndef SGB_CONFIG_SVH
`define SGB_CONFIG_SVH

// Packet framing
`define SGB_PACKET_BYTES 16

// Command codes, upper five bits of byte 0
`define SGB_CMD_PAL01    5'h00
`define SGB_CMD_PAL23    5'h01
`define SGB_CMD_PAL03    5'h02
`define SGB_CMD_PAL12    5'h03
`define SGB_CMD_ATTR_DIV 5'h06
`define SGB_CMD_MLT_REQ  5'h11
`define SGB_CMD_MASK_EN  5'h17

// Visible screen
`define SGB_TILES_X 20
`define SGB_TILES_Y 18
`define SGB_LCD_W   160
`define SGB_LCD_H   144

`endif

//--- rtl/sgb_cmd_decode.sv
`timescale 1ns/1ps
`include "sgb_config.svh"

module sgb_cmd_decode (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 ce,
	input  logic                 byte_valid,
	input  sgb_pkg::sgb_byte_t   byte_data,
	input  logic [3:0]           byte_idx,
	input  logic [2:0]           packet_idx,
	output logic [1:0]           mlt_ctrl,
	output logic [1:0]           mask_en,
	output logic                 pal_wr,
	output sgb_pkg::pal_no_t     pal_wr_no,
	output sgb_pkg::gb_shade_t   pal_wr_col,
	output sgb_pkg::color_t      pal_wr_color,
	output logic                 div_en,
	output logic                 div_hv,
	output sgb_pkg::tile_coord_t div_xy,
	output logic [5:0]           div_pal
);
	import sgb_pkg::*;

	logic [4:0] cmd;
	sgb_byte_t color_lo;
	logic take;
	logic is_pal;
	logic pal_lo;
	logic pal_hi;
	logic [2:0] pair;
	pal_no_t first_pal;
	pal_no_t second_pal;
	pal_no_t slot_pal;
	gb_shade_t slot_col;

	assign take = byte_valid & (packet_idx == 3'd0);
	assign is_pal = cmd inside {`SGB_CMD_PAL01, `SGB_CMD_PAL23, `SGB_CMD_PAL03, `SGB_CMD_PAL12};
	assign pal_lo = take & is_pal & byte_idx[0] & (byte_idx != 4'd15);
	assign pal_hi = take & is_pal & ~byte_idx[0] & (byte_idx != 4'd0);
	assign pair = byte_idx[3:1];

	always_comb begin
		case (cmd)
			`SGB_CMD_PAL23: {first_pal, second_pal} = {2'd2, 2'd3};
			`SGB_CMD_PAL03: {first_pal, second_pal} = {2'd0, 2'd3};
			`SGB_CMD_PAL12: {first_pal, second_pal} = {2'd1, 2'd2};
			default:        {first_pal, second_pal} = {2'd0, 2'd1};
		endcase
	end

	// Pair 1 is the shared colour 0, pairs 2-4 and 5-7 fill colours 1-3
	always_comb begin
		if (pair == 3'd1) begin
			slot_pal = 2'd0;
			slot_col = 2'd0;
		end else if (pair <= 3'd4) begin
			slot_pal = first_pal;
			slot_col = gb_shade_t'(pair - 3'd1);
		end else begin
			slot_pal = second_pal;
			slot_col = gb_shade_t'(pair - 3'd4);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd <= '0;
			mlt_ctrl <= '0;
			mask_en <= '0;
			pal_wr <= 1'b0;
			div_en <= 1'b0;
		end else if (ce) begin
			pal_wr <= pal_hi;
			if (take && byte_idx == 4'd0) begin
				cmd <= byte_data[7:3];
			end
			if (take && byte_idx == 4'd1 && cmd == `SGB_CMD_MLT_REQ) begin
				mlt_ctrl <= byte_data[1:0];
			end
			if (take && byte_idx == 4'd1 && cmd == `SGB_CMD_MASK_EN) begin
				mask_en <= byte_data[1:0];
			end
			if (take && byte_idx == 4'd2 && cmd == `SGB_CMD_ATTR_DIV) begin
				div_en <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ce) begin
			if (pal_lo) begin
				color_lo <= byte_data;
			end
			if (pal_hi) begin
				pal_wr_color <= {byte_data[6:0], color_lo};
				pal_wr_no <= slot_pal;
				pal_wr_col <= slot_col;
			end
			if (take && byte_idx == 4'd1 && cmd == `SGB_CMD_ATTR_DIV) begin
				{div_hv, div_pal} <= byte_data[6:0];
			end
			if (take && byte_idx == 4'd2 && cmd == `SGB_CMD_ATTR_DIV) begin
				div_xy <= byte_data[4:0];
			end
		end
	end

endmodule

//--- rtl/sgb_joypad_mux.sv
`timescale 1ns/1ps

module sgb_joypad_mux (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       ce,
	input  logic       sgb_en,
	input  logic       p14,
	input  logic       p15,
	input  logic       p15_rise,
	input  logic [1:0] mlt_ctrl,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	input  logic [7:0] joystick_2,
	input  logic [7:0] joystick_3,
	output logic [3:0] joy_do
);

	logic [1:0] player;
	logic [7:0] joystick;
	logic [3:0] joy_dir;
	logic [3:0] joy_buttons;

	// Player index, limited to the two or four players MLT_REQ asked for
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			player <= '0;
		end else if (ce) begin
			player <= p15_rise ? player + 2'd1 : player & mlt_ctrl;
		end
	end

	always_comb begin
		if (~sgb_en | ~mlt_ctrl[0]) begin
			joystick = joystick_0 | joystick_1;
		end else begin
			case (player)
				2'd0: joystick = joystick_0;
				2'd1: joystick = joystick_1;
				2'd2: joystick = joystick_2;
				default: joystick = joystick_3;
			endcase
		end
	end

	// Active low, a group reads as released while its select line is high
	assign joy_dir = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{p14}};
	assign joy_buttons = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p15}};
	assign joy_do = (sgb_en & p14 & p15) ? ~{2'b00, player} : joy_dir & joy_buttons;

endmodule

//--- rtl/sgb_lcd_colorize.sv
`timescale 1ns/1ps
`include "sgb_config.svh"

module sgb_lcd_colorize (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 ce,
	input  logic                 sgb_en,
	input  logic                 tint,
	input  logic                 is_gbc_game,
	input  logic                 lcd_clkena,
	input  logic                 lcd_on,
	input  logic                 lcd_vsync,
	input  sgb_pkg::color_t      lcd_data,
	input  sgb_pkg::gb_shade_t   lcd_data_gb,
	input  logic [1:0]           lcd_mode,
	input  logic [1:0]           mask_en,
	input  logic                 div_en,
	input  logic                 div_hv,
	input  sgb_pkg::tile_coord_t div_xy,
	input  logic [5:0]           div_pal,
	input  logic                 sgb_pal_active,
	input  sgb_pkg::color_t      rd_color,
	input  sgb_pkg::color_t      back_color,
	output sgb_pkg::pal_no_t     rd_no,
	output sgb_pkg::gb_shade_t   rd_col,
	output sgb_pkg::color_t      sgb_lcd_data,
	output logic                 sgb_lcd_clkena,
	output logic [1:0]           sgb_lcd_mode,
	output logic                 sgb_lcd_on,
	output logic                 sgb_lcd_vsync,
	output logic                 sgb_lcd_freeze,
	output logic                 sgb_pal_en
);
	import sgb_pkg::*;

	logic lcd_off;
	logic [2:0] sub_x;
	logic [2:0] sub_y;
	tile_coord_t tile_x;
	tile_coord_t tile_y;
	tile_coord_t axis;
	pal_no_t region_pal;
	logic [1:0] mask_r;
	color_t lcd_data_r;
	gb_shade_t shade_r;
	pal_no_t pal_no_r;
	logic clkena_r;
	logic on_r;
	logic vsync_r;
	logic [1:0] mode_r;
	logic pass_through;

	// Off or in vblank
	assign lcd_off = ~lcd_on | (lcd_mode == 2'd1);
	assign axis = div_hv ? tile_y : tile_x;

	always_comb begin
		if (!div_en) begin
			region_pal = 2'd0;
		end else if (axis > div_xy) begin
			region_pal = div_pal[1:0];
		end else if (axis < div_xy) begin
			region_pal = div_pal[3:2];
		end else begin
			region_pal = div_pal[5:4];
		end
	end

	// Pixel position in tiles, parked at the origin while the LCD is off
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			{sub_x, sub_y, tile_x, tile_y} <= '0;
		end else if (ce) begin
			if (lcd_off) begin
				{sub_x, sub_y, tile_x, tile_y} <= '0;
			end else if (lcd_clkena) begin
				sub_x <= sub_x + 3'd1;
				if (&sub_x) begin
					if (tile_x == tile_coord_t'(`SGB_TILES_X - 1)) begin
						tile_x <= '0;
						sub_y <= sub_y + 3'd1;
						if (&sub_y) begin
							if (tile_y == tile_coord_t'(`SGB_TILES_Y - 1)) begin
								tile_y <= '0;
							end else begin
								tile_y <= tile_y + 5'd1;
							end
						end
					end else begin
						tile_x <= tile_x + 5'd1;
					end
				end
			end
		end
	end

	assign rd_no = pal_no_r;
	assign rd_col = shade_r;
	assign pass_through = ~sgb_en | ((~sgb_pal_active | tint | is_gbc_game) & (mask_r == 2'd0));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mask_r <= '0;
			{clkena_r, on_r, vsync_r, mode_r} <= '0;
			{sgb_lcd_clkena, sgb_lcd_on, sgb_lcd_vsync, sgb_lcd_mode} <= '0;
			sgb_lcd_freeze <= 1'b0;
			sgb_pal_en <= 1'b0;
		end else if (ce) begin
			// A new mask only takes hold between frames
			if (lcd_off) begin
				mask_r <= mask_en;
			end
			{clkena_r, on_r, vsync_r, mode_r} <= {lcd_clkena, lcd_on, lcd_vsync, lcd_mode};
			{sgb_lcd_clkena, sgb_lcd_on, sgb_lcd_vsync, sgb_lcd_mode} <=
				{clkena_r, on_r, vsync_r, mode_r};
			sgb_lcd_freeze <= sgb_en & (mask_r == 2'd1);
			sgb_pal_en <= sgb_en & ((sgb_pal_active & ~tint & ~is_gbc_game) | (|mask_r));
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ce) begin
			lcd_data_r <= lcd_data;
			shade_r <= lcd_data_gb;
			pal_no_r <= region_pal;
			if (pass_through) begin
				sgb_lcd_data <= lcd_data_r;
			end else if (mask_r == 2'd2) begin
				sgb_lcd_data <= '0;
			end else if (shade_r == 2'd0 || mask_r == 2'd3) begin
				sgb_lcd_data <= back_color;
			end else begin
				sgb_lcd_data <= rd_color;
			end
		end
	end

endmodule

//--- rtl/sgb_packet_rx.sv
`timescale 1ns/1ps
`include "sgb_config.svh"

module sgb_packet_rx (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               ce,
	input  logic               sgb_en,
	input  logic               p14,
	input  logic               p15,
	output logic               byte_valid,
	output sgb_pkg::sgb_byte_t byte_data,
	output logic [3:0]         byte_idx,
	output logic [2:0]         packet_idx,
	output logic               p15_rise
);
	import sgb_pkg::*;

	rx_state_t state;
	logic old_p14;
	logic old_p15;
	logic [2:0] bit_cnt;
	logic [2:0] pkt_len;
	logic bit_strobe;
	logic line_swap;
	logic last_byte;

	// One line dropping from the idle level carries a bit
	assign bit_strobe = old_p14 & old_p15 & (p14 ^ p15);
	// Lines traded places without passing through idle
	assign line_swap = (old_p15 ^ p15) & (old_p15 ^ old_p14) & (p15 ^ p14);
	assign last_byte = byte_idx == 4'(`SGB_PACKET_BYTES - 1);
	assign p15_rise = sgb_en & ~old_p15 & p15;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= RX_IDLE;
			old_p14 <= 1'b1;
			old_p15 <= 1'b1;
			bit_cnt <= '0;
			byte_idx <= '0;
			packet_idx <= '0;
			byte_valid <= 1'b0;
		end else if (ce) begin
			old_p14 <= p14;
			old_p15 <= p15;
			byte_valid <= 1'b0;
			if (sgb_en) begin
				if (byte_valid) begin
					byte_idx <= byte_idx + 4'd1;
					if (last_byte) begin
						if ({1'b0, packet_idx} + 4'd1 >= {1'b0, pkt_len}) begin
							packet_idx <= '0;
							state <= RX_IDLE;
						end else begin
							packet_idx <= packet_idx + 3'd1;
						end
					end
				end
				if (bit_strobe && state == RX_DATA) begin
					bit_cnt <= bit_cnt + 3'd1;
					if (&bit_cnt) begin
						byte_valid <= 1'b1;
					end
				end
				if (line_swap) begin
					state <= RX_IDLE;
				end
				// Both lines low starts a packet
				if (~p14 & ~p15) begin
					state <= RX_DATA;
					bit_cnt <= '0;
					byte_idx <= '0;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ce && sgb_en) begin
			if (bit_strobe && state == RX_DATA) begin
				byte_data <= {~p15, byte_data[7:1]};
			end
			// Low three bits of the first byte give the packet count
			if (byte_valid && packet_idx == 3'd0 && byte_idx == 4'd0) begin
				pkt_len <= byte_data[2:0];
			end
		end
	end

endmodule

//--- rtl/sgb_palette.sv
`timescale 1ns/1ps

module sgb_palette (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               ce,
	input  logic               pal_wr,
	input  sgb_pkg::pal_no_t   pal_wr_no,
	input  sgb_pkg::gb_shade_t pal_wr_col,
	input  sgb_pkg::color_t    pal_wr_color,
	input  sgb_pkg::pal_no_t   rd_no,
	input  sgb_pkg::gb_shade_t rd_col,
	output sgb_pkg::color_t    rd_color,
	output sgb_pkg::color_t    back_color,
	output logic               sgb_pal_active
);
	import sgb_pkg::*;

	// Addressed by {palette, colour}
	color_t mem [0:15];
	logic clear_busy;
	logic [3:0] clear_cnt;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clear_busy <= 1'b1;
			clear_cnt <= '0;
			sgb_pal_active <= 1'b0;
		end else if (ce) begin
			if (clear_busy) begin
				clear_cnt <= clear_cnt + 4'd1;
				if (&clear_cnt) begin
					clear_busy <= 1'b0;
				end
			end
			if (pal_wr & ~clear_busy) begin
				sgb_pal_active <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ce) begin
			if (clear_busy) begin
				mem[clear_cnt] <= '0;
			end else if (pal_wr) begin
				mem[{pal_wr_no, pal_wr_col}] <= pal_wr_color;
			end
		end
	end

	assign rd_color = mem[{rd_no, rd_col}];
	// Colour 0 of palette 0 is shared by all palettes
	assign back_color = mem[0];

endmodule

//--- rtl/sgb_pkg.sv
package sgb_pkg;

	// RGB555, red in the low bits
	typedef logic [14:0] color_t;

	// Game Boy shade, also the colour slot inside a palette
	typedef logic [1:0] gb_shade_t;

	typedef logic [1:0] pal_no_t;

	// Tile column or row on the 20x18 screen
	typedef logic [4:0] tile_coord_t;

	typedef logic [7:0] sgb_byte_t;

	typedef enum logic {
		RX_IDLE,
		RX_DATA
	} rx_state_t;

endpackage

//--- rtl/sgb_top.sv
`timescale 1ns/1ps

module sgb_top (
	input  logic            clk_sys,
	input  logic            reset,
	input  logic            ce,
	input  logic            sgb_en,
	input  logic            tint,
	input  logic            is_gbc_game,
	input  logic            lcd_clkena,
	input  sgb_pkg::color_t lcd_data,
	input  logic [1:0]      lcd_data_gb,
	input  logic [1:0]      lcd_mode,
	input  logic            lcd_on,
	input  logic            lcd_vsync,
	input  logic [7:0]      joystick_0,
	input  logic [7:0]      joystick_1,
	input  logic [7:0]      joystick_2,
	input  logic [7:0]      joystick_3,
	input  logic [1:0]      joy_p54,
	output logic [3:0]      joy_do,
	output logic            sgb_pal_en,
	output sgb_pkg::color_t sgb_lcd_data,
	output logic            sgb_lcd_clkena,
	output logic [1:0]      sgb_lcd_mode,
	output logic            sgb_lcd_on,
	output logic            sgb_lcd_freeze,
	output logic            sgb_lcd_vsync
);
	import sgb_pkg::*;

	logic byte_valid;
	sgb_byte_t byte_data;
	logic [3:0] byte_idx;
	logic [2:0] packet_idx;
	logic p15_rise;
	logic [1:0] mlt_ctrl;
	logic [1:0] mask_en;
	logic pal_wr;
	pal_no_t pal_wr_no;
	gb_shade_t pal_wr_col;
	color_t pal_wr_color;
	logic div_en;
	logic div_hv;
	tile_coord_t div_xy;
	logic [5:0] div_pal;
	pal_no_t rd_no;
	gb_shade_t rd_col;
	color_t rd_color;
	color_t back_color;
	logic sgb_pal_active;

	sgb_packet_rx u_packet_rx (
		.clk_sys(clk_sys), .reset(reset), .ce(ce), .sgb_en(sgb_en),
		.p14(joy_p54[0]), .p15(joy_p54[1]),
		.byte_valid(byte_valid), .byte_data(byte_data), .byte_idx(byte_idx),
		.packet_idx(packet_idx), .p15_rise(p15_rise)
	);

	sgb_cmd_decode u_cmd_decode (
		.clk_sys(clk_sys), .reset(reset), .ce(ce),
		.byte_valid(byte_valid), .byte_data(byte_data), .byte_idx(byte_idx),
		.packet_idx(packet_idx), .mlt_ctrl(mlt_ctrl), .mask_en(mask_en),
		.pal_wr(pal_wr), .pal_wr_no(pal_wr_no), .pal_wr_col(pal_wr_col),
		.pal_wr_color(pal_wr_color), .div_en(div_en), .div_hv(div_hv),
		.div_xy(div_xy), .div_pal(div_pal)
	);

	sgb_joypad_mux u_joypad_mux (
		.clk_sys(clk_sys), .reset(reset), .ce(ce), .sgb_en(sgb_en),
		.p14(joy_p54[0]), .p15(joy_p54[1]), .p15_rise(p15_rise), .mlt_ctrl(mlt_ctrl),
		.joystick_0(joystick_0), .joystick_1(joystick_1),
		.joystick_2(joystick_2), .joystick_3(joystick_3), .joy_do(joy_do)
	);

	sgb_palette u_palette (
		.clk_sys(clk_sys), .reset(reset), .ce(ce),
		.pal_wr(pal_wr), .pal_wr_no(pal_wr_no), .pal_wr_col(pal_wr_col),
		.pal_wr_color(pal_wr_color), .rd_no(rd_no), .rd_col(rd_col),
		.rd_color(rd_color), .back_color(back_color), .sgb_pal_active(sgb_pal_active)
	);

	sgb_lcd_colorize u_colorize (
		.clk_sys(clk_sys), .reset(reset), .ce(ce), .sgb_en(sgb_en),
		.tint(tint), .is_gbc_game(is_gbc_game),
		.lcd_clkena(lcd_clkena), .lcd_on(lcd_on), .lcd_vsync(lcd_vsync),
		.lcd_data(lcd_data), .lcd_data_gb(lcd_data_gb), .lcd_mode(lcd_mode),
		.mask_en(mask_en), .div_en(div_en), .div_hv(div_hv), .div_xy(div_xy),
		.div_pal(div_pal), .sgb_pal_active(sgb_pal_active),
		.rd_color(rd_color), .back_color(back_color), .rd_no(rd_no), .rd_col(rd_col),
		.sgb_lcd_data(sgb_lcd_data), .sgb_lcd_clkena(sgb_lcd_clkena),
		.sgb_lcd_mode(sgb_lcd_mode), .sgb_lcd_on(sgb_lcd_on),
		.sgb_lcd_vsync(sgb_lcd_vsync), .sgb_lcd_freeze(sgb_lcd_freeze),
		.sgb_pal_en(sgb_pal_en)
	);

endmodule
